// File: hw/tinyCore_settings.svh
// tiny accumulator core settings
// widths, queue depth and register counts shared by every block

`ifndef TINYCORE_SETTINGS_SVH
`define TINYCORE_SETTINGS_SVH

// register and data path width
`define DATA_WIDTH 8

// raw instruction width, top bit picks set-immediate or opcode form
`define INSTR_WIDTH 9

// micro-op queue entries, also the decoder's starting credit count
`define QUEUE_DEPTH 4

// temporaries t0..t3
`define NUM_TEMP 4

// accumulators acc0..acc5
`define NUM_ACC 6

`endif

// File: hw/tinyCorePkg.sv
// tiny accumulator core types
// instruction views, register ids, opcodes, ALU ops, micro-op and
// write-back records

`include "tinyCore_settings.svh"

package tinyCorePkg;

  // set immediate view, top bit clear
  typedef struct packed {
    logic                    isOp;
    logic [`INSTR_WIDTH-2:0] imm;
  } setImm_t;

  // opcode view, top bit set
  typedef struct packed {
    logic       isOp;
    logic [5:0] opcode;
    logic [1:0] arg;
  } opForm_t;

  // one 9-bit word, two decodings
  typedef union packed {
    setImm_t setImm;
    opForm_t opForm;
  } instrWord_t;

  // as a hex digit: 0..5 are acc0..acc5, 8..b are t0..t3
  typedef struct packed {
    logic       isTemp;
    logic [2:0] index;
  } regId_t;

  // kept opcodes only, anything else is dropped by the decoder
  typedef enum logic [5:0] {
    OP_LDR1  = 6'b000101,
    OP_LDR4  = 6'b000110,
    OP_LDR5  = 6'b000111,
    OP_ADD1  = 6'b001000,
    OP_ADD4  = 6'b001001,
    OP_ADD5  = 6'b001010,
    OP_SUB1  = 6'b001101,
    OP_SUB3  = 6'b001110,
    OP_SUB4  = 6'b001111,
    OP_SUB5  = 6'b010000,
    OP_STR1  = 6'b010010,
    OP_STR2  = 6'b010011,
    OP_STR3  = 6'b010100,
    OP_MOV   = 6'b011010,
    OP_SRL   = 6'b011011,
    OP_SRA   = 6'b011100,
    OP_ZERO0 = 6'b100010,
    OP_ZERO2 = 6'b100011,
    OP_ZERO3 = 6'b100100,
    OP_ZERO4 = 6'b100101,
    OP_SRL4  = 6'b100110,
    OP_SRA5  = 6'b100111,
    OP_SLF0  = 6'b101001,
    OP_SLF1  = 6'b101010,
    OP_SLF2  = 6'b101011,
    OP_CP0_5 = 6'b101111,
    OP_ADD25 = 6'b110000,
    OP_SUB25 = 6'b110001,
    OP_HALT  = 6'b110110
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_PASS  = 3'd0,
    ALU_ADD   = 3'd1,
    ALU_SUB   = 3'd2,
    ALU_SRL   = 3'd3,
    ALU_SRA   = 3'd4,
    ALU_SLL   = 3'd5,
    ALU_CLEAR = 3'd6
  } aluOp_e;

  // result = srcA op srcB, or imm when pass has useImm set
  // halt: aluOp clear, dst equal to srcA, top bit of imm set
  typedef struct packed {
    regId_t                 dst;
    regId_t                 srcA;
    regId_t                 srcB;
    aluOp_e                 aluOp;
    logic                   useImm;
    logic [`DATA_WIDTH-1:0] imm;
  } microOp_t;

  // one record per register write
  typedef struct packed {
    regId_t                 dst;
    logic [`DATA_WIDTH-1:0] data;
  } wbRecord_t;

endpackage

// File: hw/instrDecoder.sv
// instruction decoder
// turns accepted 9-bit instructions into micro-ops for the queue and
// keeps one credit per free queue entry

`timescale 1ns/1ns

`include "tinyCore_settings.svh"

module instrDecoder (
  input  logic                   clk,
  input  logic                   reset,
  input  tinyCorePkg::instrWord_t instr,
  input  logic                   instrValid,
  output logic                   instrReady,
  input  logic                   creditReturn,
  output logic                   pushValid,
  output tinyCorePkg::microOp_t  pushOp
);

  localparam int CREDIT_W = $clog2(`QUEUE_DEPTH + 1);

  logic [CREDIT_W-1:0]   credits;
  tinyCorePkg::microOp_t decOp;
  logic                  decKeep;
  tinyCorePkg::regId_t   argT;
  logic                  accept;
  logic                  spend;

  // accumulator id from index
  function automatic tinyCorePkg::regId_t accId(input logic [2:0] idx);
    tinyCorePkg::regId_t id;
    id.isTemp = 1'b0;
    id.index  = idx;
    return id;
  endfunction

  // temporary id from index
  function automatic tinyCorePkg::regId_t tmpId(input logic [1:0] idx);
    tinyCorePkg::regId_t id;
    id.isTemp = 1'b1;
    id.index  = {1'b0, idx};
    return id;
  endfunction

  // register-only micro-op, no immediate
  function automatic tinyCorePkg::microOp_t mkOp(
    input tinyCorePkg::regId_t dst,
    input tinyCorePkg::regId_t srcA,
    input tinyCorePkg::regId_t srcB,
    input tinyCorePkg::aluOp_e aluOp
  );
    tinyCorePkg::microOp_t op;
    op.dst    = dst;
    op.srcA   = srcA;
    op.srcB   = srcB;
    op.aluOp  = aluOp;
    op.useImm = 1'b0;
    op.imm    = '0;
    return op;
  endfunction

  // ready only on credit, never looks at instrValid
  assign instrReady = (credits != '0);
  assign accept     = instrValid && instrReady;
  // dropped opcodes are accepted but cost nothing
  assign spend      = accept && decKeep;

  // the temporary named by the arg field
  assign argT = tmpId(instr.opForm.arg);

  always_comb begin
    decOp   = mkOp(accId(3'd0), accId(3'd0), accId(3'd0), tinyCorePkg::ALU_PASS);
    decKeep = 1'b1;
    if (!instr.setImm.isOp) begin
      // set immediate into t0
      decOp        = mkOp(tmpId(2'd0), tmpId(2'd0), tmpId(2'd0), tinyCorePkg::ALU_PASS);
      decOp.useImm = 1'b1;
      decOp.imm    = instr.setImm.imm;
    end else begin
      case (instr.opForm.opcode)
        // loads from a temporary
        tinyCorePkg::OP_LDR1: decOp = mkOp(accId(3'd1), argT, argT, tinyCorePkg::ALU_PASS);
        tinyCorePkg::OP_LDR4: decOp = mkOp(accId(3'd4), argT, argT, tinyCorePkg::ALU_PASS);
        tinyCorePkg::OP_LDR5: decOp = mkOp(accId(3'd5), argT, argT, tinyCorePkg::ALU_PASS);
        // accumulator plus or minus temporary
        tinyCorePkg::OP_ADD1: decOp = mkOp(accId(3'd1), accId(3'd1), argT, tinyCorePkg::ALU_ADD);
        tinyCorePkg::OP_ADD4: decOp = mkOp(accId(3'd4), accId(3'd4), argT, tinyCorePkg::ALU_ADD);
        tinyCorePkg::OP_ADD5: decOp = mkOp(accId(3'd5), accId(3'd5), argT, tinyCorePkg::ALU_ADD);
        tinyCorePkg::OP_SUB1: decOp = mkOp(accId(3'd1), accId(3'd1), argT, tinyCorePkg::ALU_SUB);
        tinyCorePkg::OP_SUB3: decOp = mkOp(accId(3'd3), accId(3'd3), argT, tinyCorePkg::ALU_SUB);
        tinyCorePkg::OP_SUB4: decOp = mkOp(accId(3'd4), accId(3'd4), argT, tinyCorePkg::ALU_SUB);
        tinyCorePkg::OP_SUB5: decOp = mkOp(accId(3'd5), accId(3'd5), argT, tinyCorePkg::ALU_SUB);
        // stores into a temporary
        tinyCorePkg::OP_STR1: decOp = mkOp(argT, accId(3'd1), argT, tinyCorePkg::ALU_PASS);
        tinyCorePkg::OP_STR2: decOp = mkOp(argT, accId(3'd2), argT, tinyCorePkg::ALU_PASS);
        tinyCorePkg::OP_STR3: decOp = mkOp(argT, accId(3'd3), argT, tinyCorePkg::ALU_PASS);
        tinyCorePkg::OP_MOV:  decOp = mkOp(argT, tmpId(2'd0), argT, tinyCorePkg::ALU_PASS);
        // in-place shifts of a temporary
        tinyCorePkg::OP_SRL:  decOp = mkOp(argT, argT, argT, tinyCorePkg::ALU_SRL);
        tinyCorePkg::OP_SRA:  decOp = mkOp(argT, argT, argT, tinyCorePkg::ALU_SRA);
        // clears, sources unused
        tinyCorePkg::OP_ZERO0: decOp = mkOp(accId(3'd0), accId(3'd0), accId(3'd0),
                                            tinyCorePkg::ALU_CLEAR);
        tinyCorePkg::OP_ZERO2: decOp = mkOp(accId(3'd2), accId(3'd2), accId(3'd2),
                                            tinyCorePkg::ALU_CLEAR);
        tinyCorePkg::OP_ZERO3: decOp = mkOp(accId(3'd3), accId(3'd3), accId(3'd3),
                                            tinyCorePkg::ALU_CLEAR);
        tinyCorePkg::OP_ZERO4: decOp = mkOp(accId(3'd4), accId(3'd4), accId(3'd4),
                                            tinyCorePkg::ALU_CLEAR);
        // in-place accumulator shifts
        tinyCorePkg::OP_SRL4: decOp = mkOp(accId(3'd4), accId(3'd4), accId(3'd4),
                                           tinyCorePkg::ALU_SRL);
        tinyCorePkg::OP_SRA5: decOp = mkOp(accId(3'd5), accId(3'd5), accId(3'd5),
                                           tinyCorePkg::ALU_SRA);
        tinyCorePkg::OP_SLF0: decOp = mkOp(accId(3'd0), accId(3'd0), accId(3'd0),
                                           tinyCorePkg::ALU_SLL);
        tinyCorePkg::OP_SLF1: decOp = mkOp(accId(3'd1), accId(3'd1), accId(3'd1),
                                           tinyCorePkg::ALU_SLL);
        tinyCorePkg::OP_SLF2: decOp = mkOp(accId(3'd2), accId(3'd2), accId(3'd2),
                                           tinyCorePkg::ALU_SLL);
        // acc0 into acc5
        tinyCorePkg::OP_CP0_5: decOp = mkOp(accId(3'd5), accId(3'd0), accId(3'd0),
                                            tinyCorePkg::ALU_PASS);
        // acc2 with acc5, result lands in acc2
        tinyCorePkg::OP_ADD25: decOp = mkOp(accId(3'd2), accId(3'd2), accId(3'd5),
                                            tinyCorePkg::ALU_ADD);
        tinyCorePkg::OP_SUB25: decOp = mkOp(accId(3'd2), accId(3'd2), accId(3'd5),
                                            tinyCorePkg::ALU_SUB);
        tinyCorePkg::OP_HALT: begin
          // clear with marker bit, executor stops on it
          decOp = mkOp(accId(3'd0), accId(3'd0), accId(3'd0), tinyCorePkg::ALU_CLEAR);
          decOp.imm[`DATA_WIDTH-1] = 1'b1;
        end
        // memory, branch, flag and 3-operand forms
        default: decKeep = 1'b0;
      endcase
    end
  end

  // micro-op register, one push per kept instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      pushValid <= 1'b0;
    end else begin
      pushValid <= spend;
    end
    if (spend) begin
      pushOp <= decOp;
    end
  end

  // credit taken at decode so the registered push always has a slot
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CREDIT_W'(`QUEUE_DEPTH);
    end else begin
      case ({spend, creditReturn})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

// File: hw/microOpQueue.sv
// micro-op queue
// circular FIFO between decoder and executor, one credit back per pop

`timescale 1ns/1ns

`include "tinyCore_settings.svh"

module microOpQueue (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pushValid,
  input  tinyCorePkg::microOp_t pushOp,
  output logic                  popValid,
  output tinyCorePkg::microOp_t popOp,
  input  logic                  popTake,
  output logic                  creditReturn
);

  localparam int PTR_W   = $clog2(`QUEUE_DEPTH);
  localparam int COUNT_W = $clog2(`QUEUE_DEPTH + 1);

  tinyCorePkg::microOp_t entries [`QUEUE_DEPTH];
  logic [PTR_W-1:0]      wrPtr;
  logic [PTR_W-1:0]      rdPtr;
  logic [COUNT_W-1:0]    count;
  logic                  doPop;

  // wrap at depth, depth need not be a power of two
  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign popValid = (count != '0);
  assign popOp    = entries[rdPtr];
  assign doPop    = popTake && popValid;

  // storage, no reset
  always_ff @(posedge clk) begin
    if (pushValid) begin
      entries[wrPtr] <= pushOp;
    end
  end

  // pointers and occupancy
  // credits upstream keep pushes off a full queue
  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (pushValid) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doPop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({pushValid, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // credit pulse a cycle after each pop
  always_ff @(posedge clk) begin
    if (reset) begin
      creditReturn <= 1'b0;
    end else begin
      creditReturn <= doPop;
    end
  end

endmodule

// File: hw/accumulatorExec.sv
// accumulator executor
// holds t0..t3 and acc0..acc5, runs one micro-op per cycle and
// reports each register write; stops for good on halt

`timescale 1ns/1ns

`include "tinyCore_settings.svh"

module accumulatorExec (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   popValid,
  input  tinyCorePkg::microOp_t  popOp,
  output logic                   popTake,
  output logic                   wbValid,
  output tinyCorePkg::wbRecord_t wb,
  output logic                   halted
);

  logic [`DATA_WIDTH-1:0] tempRegs [`NUM_TEMP];
  logic [`DATA_WIDTH-1:0] accRegs  [`NUM_ACC];
  logic [`DATA_WIDTH-1:0] opA;
  logic [`DATA_WIDTH-1:0] opB;
  logic [`DATA_WIDTH-1:0] result;
  logic                   isHaltOp;

  // take while something waits and not halted
  assign popTake = popValid && !halted;

  // operand read, temporaries use the low index bits
  assign opA = popOp.srcA.isTemp ? tempRegs[popOp.srcA.index[1:0]]
                                 : accRegs[popOp.srcA.index];
  assign opB = popOp.srcB.isTemp ? tempRegs[popOp.srcB.index[1:0]]
                                 : accRegs[popOp.srcB.index];

  // halt marker, as encoded by the decoder
  assign isHaltOp = (popOp.aluOp == tinyCorePkg::ALU_CLEAR)
                 && popOp.imm[`DATA_WIDTH-1]
                 && (popOp.dst == popOp.srcA);

  // ALU, everything wraps at 8 bits
  always_comb begin
    case (popOp.aluOp)
      tinyCorePkg::ALU_PASS:  result = popOp.useImm ? popOp.imm : opA;
      tinyCorePkg::ALU_ADD:   result = opA + opB;
      tinyCorePkg::ALU_SUB:   result = opA - opB;
      // single-bit shifts
      tinyCorePkg::ALU_SRL:   result = {1'b0, opA[`DATA_WIDTH-1:1]};
      tinyCorePkg::ALU_SRA:   result = {opA[`DATA_WIDTH-1], opA[`DATA_WIDTH-1:1]};
      tinyCorePkg::ALU_SLL:   result = {opA[`DATA_WIDTH-2:0], 1'b0};
      tinyCorePkg::ALU_CLEAR: result = '0;
      default:                result = '0;
    endcase
  end

  // register file write
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_TEMP; i++) begin
        tempRegs[i] <= '0;
      end
      for (int i = 0; i < `NUM_ACC; i++) begin
        accRegs[i] <= '0;
      end
    end else if (popTake && !isHaltOp) begin
      if (popOp.dst.isTemp) begin
        tempRegs[popOp.dst.index[1:0]] <= result;
      end else begin
        accRegs[popOp.dst.index] <= result;
      end
    end
  end

  // halt state and write-back valid
  always_ff @(posedge clk) begin
    if (reset) begin
      halted  <= 1'b0;
      wbValid <= 1'b0;
    end else begin
      wbValid <= popTake && !isHaltOp;
      if (popTake && isHaltOp) begin
        halted <= 1'b1;
      end
    end
  end

  // write-back payload, same cycle as the register update
  always_ff @(posedge clk) begin
    if (popTake && !isHaltOp) begin
      wb.dst  <= popOp.dst;
      wb.data <= result;
    end
  end

endmodule

// File: hw/tinyCore.sv
// tiny accumulator core top
// decoder feeds micro-ops into the queue on credit, executor drains
// them and reports register writes

`timescale 1ns/1ns

module tinyCore (
  input  logic                   clk,
  input  logic                   reset,
  input  tinyCorePkg::instrWord_t instr,
  input  logic                   instrValid,
  output logic                   instrReady,
  output logic                   wbValid,
  output tinyCorePkg::wbRecord_t wb,
  output logic                   halted
);

  // decoder to queue
  logic                  pushValid;
  tinyCorePkg::microOp_t pushOp;
  logic                  creditReturn;

  // queue to executor
  logic                  popValid;
  tinyCorePkg::microOp_t popOp;
  logic                  popTake;

  instrDecoder i_decoder (
    .clk          (clk),
    .reset        (reset),
    .instr        (instr),
    .instrValid   (instrValid),
    .instrReady   (instrReady),
    .creditReturn (creditReturn),
    .pushValid    (pushValid),
    .pushOp       (pushOp)
  );

  microOpQueue i_queue (
    .clk          (clk),
    .reset        (reset),
    .pushValid    (pushValid),
    .pushOp       (pushOp),
    .popValid     (popValid),
    .popOp        (popOp),
    .popTake      (popTake),
    .creditReturn (creditReturn)
  );

  accumulatorExec i_exec (
    .clk      (clk),
    .reset    (reset),
    .popValid (popValid),
    .popOp    (popOp),
    .popTake  (popTake),
    .wbValid  (wbValid),
    .wb       (wb),
    .halted   (halted)
  );

endmodule

// File: testbench/tinyCoreTb.sv
// testbench for the tiny accumulator core
// replays the pattern file, checks every write-back in program order,
// then shows that the core stops and back-pressures after halt

`timescale 1ns/1ns

`include "tinyCore_settings.svh"

module tinyCoreTb;

  localparam int MAX_LINES     = 128;
  localparam int CLK_HALF      = 2;
  localparam int RESET_CYCLES  = 10;
  // ready must hold low this long once the queue has filled
  localparam int HOLD_CYCLES   = 16;

  logic                    clk;
  logic                    reset;
  tinyCorePkg::instrWord_t instr;
  logic                    instrValid;
  logic                    instrReady;
  logic                    wbValid;
  tinyCorePkg::wbRecord_t  wb;
  logic                    halted;

  logic [15:0] patterns [MAX_LINES];
  logic [8:0]  sendQ [$];
  logic [11:0] expectQ [$];
  integer      seed;
  int          numLines;
  int          timeoutLimit;
  int          cycleCount;
  int          valueErrs;
  int          flowErrs;
  int          stateErrs;
  logic        endSeen;

  tinyCore i_dut (
    .clk        (clk),
    .reset      (reset),
    .instr      (instr),
    .instrValid (instrValid),
    .instrReady (instrReady),
    .wbValid    (wbValid),
    .wb         (wb),
    .halted     (halted)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #CLK_HALF clk = ~clk;
    end
  end

  // split pattern lines into send and expect queues
  task automatic loadPatterns();
    logic [15:0] line;
    for (int i = 0; i < MAX_LINES; i++) begin
      patterns[i] = '0;
    end
    $readmemh("testbench/corePatterns.hex", patterns);
    numLines = 0;
    endSeen  = 1'b0;
    for (int i = 0; i < MAX_LINES; i++) begin
      line = patterns[i];
      if (!endSeen) begin
        case (line[15:12])
          4'h1: sendQ.push_back(line[8:0]);
          4'h2: expectQ.push_back(line[11:0]);
          4'h3: endSeen = 1'b1;
          default: ;
        endcase
        if (line[15:12] inside {4'h1, 4'h2, 4'h3}) begin
          numLines++;
        end
      end
    end
  endtask

  // offer one word with random idle cycles until it is taken
  // ready is sampled at the falling edge, transfer is the next rise
  task automatic offerInstr(input logic [8:0] word);
    logic idle;
    logic took;
    took = 1'b0;
    while (!took) begin
      @(posedge clk);
      idle = (($random(seed) & 3) < 2);
      instr      <= tinyCorePkg::instrWord_t'(word);
      instrValid <= !idle;
      @(negedge clk);
      if (!idle && instrReady) begin
        took = 1'b1;
      end
    end
  endtask

  task automatic reportCounts();
    $display("errors: value %0d, flow %0d, state %0d", valueErrs, flowErrs, stateErrs);
  endtask

  // write-back checker, outputs are stable at the falling edge
  always @(negedge clk) begin
    logic [11:0] exp;
    if (!reset && wbValid) begin
      assert (!halted) else begin
        flowErrs++;
        $display("write-back to register %h appeared after halt", wb.dst);
      end
      assert (expectQ.size() > 0) else begin
        flowErrs++;
        $display("extra write-back with no expected entry, dst %h data %h", wb.dst, wb.data);
      end
      if (expectQ.size() > 0) begin
        exp = expectQ.pop_front();
        assert (wb.dst == exp[11:8]) else begin
          valueErrs++;
          $display("ERR wb.dst got %h expected %h", wb.dst, exp[11:8]);
        end
        assert (wb.data == exp[7:0]) else begin
          valueErrs++;
          $display("ERR wb.data got %h expected %h", wb.data, exp[7:0]);
        end
      end
    end
  end

  // run limit from the pattern length
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > timeoutLimit) begin
      $display("timeout: run went past %0d cycles", timeoutLimit);
      reportCounts();
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    logic [31:0] rnd;
    int          accepted;
    int          lowCycles;
    seed         = 32'hf00d;
    reset        = 1'b1;
    instr        = '0;
    instrValid   = 1'b0;
    cycleCount   = 0;
    valueErrs    = 0;
    flowErrs     = 0;
    stateErrs    = 0;
    loadPatterns();
    timeoutLimit = 20 * numLines + 200;
    assert (endSeen) else begin
      stateErrs++;
      $display("pattern file has no end-of-program line");
    end

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    // idle state straight out of reset
    assert (instrReady) else begin
      stateErrs++;
      $display("instrReady is low after reset");
    end
    assert (!wbValid) else begin
      stateErrs++;
      $display("wbValid is high after reset");
    end
    assert (!halted) else begin
      stateErrs++;
      $display("halted is high after reset");
    end

    // program up to and including halt
    while (sendQ.size() > 0) begin
      offerInstr(sendQ.pop_front());
    end

    // keep offering after halt until ready has held low long enough
    accepted  = 0;
    lowCycles = 0;
    while (lowCycles < HOLD_CYCLES) begin
      @(posedge clk);
      rnd = $random(seed);
      instr      <= tinyCorePkg::instrWord_t'({1'b0, rnd[7:0]});
      instrValid <= 1'b1;
      @(negedge clk);
      if (instrReady) begin
        accepted++;
        assert (lowCycles == 0) else begin
          stateErrs++;
          $display("instrReady went high again after %0d low cycles", lowCycles);
        end
      end else begin
        lowCycles++;
      end
    end
    @(posedge clk);
    instrValid <= 1'b0;
    @(negedge clk);

    assert (halted) else begin
      stateErrs++;
      $display("halted never rose after the halt instruction");
    end
    assert (accepted <= `QUEUE_DEPTH + 2) else begin
      flowErrs++;
      $display("%0d instructions accepted after halt, limit is %0d", accepted,
               `QUEUE_DEPTH + 2);
    end

    // write-backs stop once halted, nothing may be left outstanding
    @(posedge clk);
    assert (expectQ.size() == 0) else begin
      flowErrs++;
      $display("%0d expected write-backs never arrived", expectQ.size());
    end

    reportCounts();
    if (valueErrs == 0 && flowErrs == 0 && stateErrs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/corePatterns.hex
// one 16-bit word per line, top digit: 1 = instruction in bits 8:0,
// 2 = write-back with register id in 11:8 and data in 7:0, 3 = end, halt expected
105A  // set t0 = 5a
285A
1169  // mov t1 from t0
295A
1115  // ldr1 from t1
215A
10C3  // set t0 = c3
28C3
1118  // ldr4 from t0
24C3
111C  // ldr5 from t0
25C3
1120  // add1 t0, carry wraps
211D
1139  // sub3 t1, borrow wraps
23A6
1125  // add4 t1
241D
113C  // sub4 t0
245A
1128  // add5 t0
2586
1141  // sub5 t1
252C
1135  // sub1 t1
21C3
1100  // ldm0, dropped
11FF  // unused opcode, dropped
114A  // str1 into t2
2AC3
1153  // str3 into t3
2BA6
11C0  // add25
222C
114E  // str2 into t2
2A2C
11C4  // sub25 to zero
2200
11C4  // sub25 wraps
22D4
116F  // srl t3, zero fill
2B53
1170  // sra t0, sign kept
28E1
1173  // sra t3
2B29
1198  // srl4
242D
111C  // ldr5 from t0, now e1
25E1
119C  // sra5
25F0
11A8  // slf1
2186
11AC  // slf2
22A8
11A4  // slf0
2000
11BC  // cp0_5
2500
1188  // zero0
2000
118C  // zero2
2200
1190  // zero3
2300
1194  // zero4
2400
11D8  // halt
3000

// File: vlog.f
+incdir+hw
hw/tinyCorePkg.sv
hw/instrDecoder.sv
hw/microOpQueue.sv
hw/accumulatorExec.sv
hw/tinyCore.sv
testbench/tinyCoreTb.sv

// File: Makefile
# Verilator build and run for the tiny core testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tinyCoreTb -o simv

run: compile
	./obj_dir/simv | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
